// ==== verilog/pkt_gen_pkg.sv ====
package pkt_gen_pkg;

    ////////////////////////////////////////
    // Stream geometry
    ////////////////////////////////////////
    localparam int BEAT_BYTES = 64;
    localparam int DATA_W     = 512;
    localparam int KEEP_W     = 64;

    localparam int PKT_NUM_W  = 16;
    localparam int PKT_SIZE_W = 14;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_PKT_NUM  = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_PKT_SIZE = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 4'hC;

    // Status word bits
    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;
    localparam int STAT_FAIL    = 2;
    localparam int STAT_ALIGNED = 3;

    ////////////////////////////////////////
    // Payload pattern
    ////////////////////////////////////////
    localparam logic [7:0] PATTERN_FIRST = 8'd6;
    localparam logic [7:0] PATTERN_LAST  = 8'd255;

endpackage

// ==== verilog/pkt_gen_regs.sv ====
`timescale 1ns/10ps

module pkt_gen_regs
    import pkt_gen_pkg::*;
#(
    parameter int DEFAULT_PKT_NUM  = 4,
    parameter int DEFAULT_PKT_SIZE = 522
)
(
    input  logic                   clk,
    input  logic                   sys_reset,

    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [AXIL_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [AXIL_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,

    output logic                   start,
    output logic [PKT_NUM_W-1:0]   pkt_num,
    output logic [PKT_SIZE_W-1:0]  pkt_size,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   fail,
    input  logic                   aligned
);

    logic                   wr_fire;
    logic                   rd_fire;
    logic [AXIL_DATA_W-1:0] status_word;
    logic [AXIL_DATA_W-1:0] rd_mux;

    assign wr_fire = awready & awvalid & wvalid;
    assign rd_fire = arready & arvalid;

    // Always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            start    <= 1'b0;
            pkt_num  <= PKT_NUM_W'(DEFAULT_PKT_NUM);
            pkt_size <= PKT_SIZE_W'(DEFAULT_PKT_SIZE);
        end
        else
        begin
            // Single-cycle accept of address and data together
            awready <= awvalid & wvalid & ~bvalid & ~awready;
            wready  <= awvalid & wvalid & ~bvalid & ~awready;
            start   <= wr_fire && (awaddr == REG_CTRL) && wdata[0];

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (wr_fire)
            begin
                case (awaddr)
                    REG_PKT_NUM:  pkt_num  <= wdata[PKT_NUM_W-1:0];
                    REG_PKT_SIZE: pkt_size <= wdata[PKT_SIZE_W-1:0];
                    default:      ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////
    always_comb
    begin
        status_word               = '0;
        status_word[STAT_BUSY]    = busy;
        status_word[STAT_DONE]    = done;
        status_word[STAT_FAIL]    = fail;
        status_word[STAT_ALIGNED] = aligned;
    end

    always_comb
    begin
        case (araddr)
            REG_PKT_NUM:  rd_mux = AXIL_DATA_W'(pkt_num);
            REG_PKT_SIZE: rd_mux = AXIL_DATA_W'(pkt_size);
            REG_STATUS:   rd_mux = status_word;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= arvalid & ~rvalid & ~arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
            rdata <= rd_mux;
    end

endmodule

// ==== verilog/pkt_gen_seq.sv ====
`timescale 1ns/10ps

module pkt_gen_seq #(
    parameter int INIT_WAIT = 16
)
(
    input  logic clk,
    input  logic sys_reset,
    input  logic start,
    input  logic rx_aligned,
    input  logic tx_ovfout,
    input  logic tx_unfout,
    input  logic frames_done,
    output logic load,
    output logic stream_en,
    output logic busy,
    output logic done,
    output logic fail,
    output logic aligned
);

    localparam int CNT_W = $clog2(INIT_WAIT + 1);

    localparam logic [2:0] LINK_WAIT = 3'd0;
    localparam logic [2:0] READY     = 3'd1;
    localparam logic [2:0] SETTLE    = 3'd2;
    localparam logic [2:0] STREAM    = 3'd3;
    localparam logic [2:0] HALT      = 3'd4;
    localparam logic [2:0] FINISH    = 3'd5;

    logic [2:0]       state;
    logic [CNT_W-1:0] settle_cnt;
    logic             fault;

    assign stream_en = (state == STREAM);

    // MAC status inputs
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            aligned <= 1'b0;
            fault   <= 1'b0;
        end
        else
        begin
            aligned <= rx_aligned;
            fault   <= tx_ovfout | tx_unfout;
        end
    end

    ////////////////////////////////////////
    // Run state machine
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            state      <= LINK_WAIT;
            settle_cnt <= '0;
            load       <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            fail       <= 1'b0;
        end
        else
        begin
            load <= 1'b0;
            if (!aligned)
            begin
                state <= LINK_WAIT;
                busy  <= 1'b0;
                // Link dropped in the middle of a run
                if (busy)
                begin
                    done <= 1'b1;
                    fail <= 1'b1;
                end
            end
            else
            begin
                case (state)
                    LINK_WAIT:
                        state <= READY;
                    READY:
                        if (start)
                        begin
                            done       <= 1'b0;
                            fail       <= 1'b0;
                            load       <= 1'b1;
                            busy       <= 1'b1;
                            settle_cnt <= '0;
                            state      <= SETTLE;
                        end
                    SETTLE:
                        if (settle_cnt == CNT_W'(INIT_WAIT - 1))
                            state <= STREAM;
                        else
                            settle_cnt <= settle_cnt + 1'b1;
                    // Status closes as FINISH is entered, one cycle after frames_done
                    STREAM:
                        if (frames_done)
                        begin
                            done  <= 1'b1;
                            busy  <= 1'b0;
                            state <= FINISH;
                        end
                        else if (fault)
                            state <= HALT;
                    HALT:
                        if (fault || frames_done)
                        begin
                            done  <= 1'b1;
                            fail  <= fault;
                            busy  <= 1'b0;
                            state <= FINISH;
                        end
                        else
                            state <= STREAM;
                    FINISH:
                        state <= READY;
                    default:
                        state <= LINK_WAIT;
                endcase
            end
        end
    end

endmodule

// ==== verilog/pkt_gen_frame.sv ====
`timescale 1ns/10ps

module pkt_gen_frame
    import pkt_gen_pkg::*;
(
    input  logic                  clk,
    input  logic                  sys_reset,
    input  logic                  load,
    input  logic                  stream_en,
    input  logic [PKT_NUM_W-1:0]  pkt_num,
    input  logic [PKT_SIZE_W-1:0] pkt_size,
    input  logic                  tready,
    output logic                  tvalid,
    output logic [DATA_W-1:0]     tdata,
    output logic [KEEP_W-1:0]     tkeep,
    output logic                  tlast,
    output logic                  frames_done
);

    localparam int REM_W = $clog2(BEAT_BYTES);

    logic [PKT_SIZE_W-1:0] bytes_left;
    logic [PKT_NUM_W-1:0]  pkts_left;
    logic [PKT_SIZE_W-1:0] size_q;
    logic [7:0]            pattern;
    logic [REM_W-1:0]      rem;
    logic [KEEP_W-1:0]     last_keep;
    logic                  accept;
    logic                  take;
    logic                  pkt_end;
    logic                  run_end;

    assign accept  = tvalid & tready;
    // Output slot free or draining this cycle
    assign take    = stream_en && (pkts_left != '0) && (!tvalid || tready);
    assign pkt_end = (bytes_left <= PKT_SIZE_W'(BEAT_BYTES));

    // Last beat keep, low rem lanes or a full beat
    assign rem       = size_q[REM_W-1:0];
    assign last_keep = (rem == '0) ? {KEEP_W{1'b1}}
                                   : {KEEP_W{1'b1}} >> (BEAT_BYTES - int'(rem));

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            tvalid      <= 1'b0;
            tlast       <= 1'b0;
            run_end     <= 1'b0;
            frames_done <= 1'b0;
            bytes_left  <= '0;
            pkts_left   <= '0;
        end
        else
        begin
            frames_done <= accept & run_end & ~load;

            if (take)
            begin
                tvalid  <= 1'b1;
                tlast   <= pkt_end;
                run_end <= pkt_end && (pkts_left == PKT_NUM_W'(1));
            end
            else if (accept)
            begin
                tvalid  <= 1'b0;
                tlast   <= 1'b0;
                run_end <= 1'b0;
            end

            if (load)
            begin
                bytes_left <= pkt_size;
                pkts_left  <= pkt_num;
                run_end    <= 1'b0;
            end
            else if (take)
            begin
                if (pkt_end)
                begin
                    bytes_left <= size_q;
                    pkts_left  <= pkts_left - 1'b1;
                end
                else
                    bytes_left <= bytes_left - PKT_SIZE_W'(BEAT_BYTES);
            end
        end
    end

    ////////////////////////////////////////
    // Beat payload
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            size_q  <= pkt_size;
            pattern <= PATTERN_FIRST;
        end
        else if (take && pkt_end)
            pattern <= (pattern == PATTERN_LAST) ? PATTERN_FIRST : pattern + 8'd1;

        if (take)
        begin
            tdata <= {BEAT_BYTES{pattern}};
            tkeep <= pkt_end ? last_keep : {KEEP_W{1'b1}};
        end
    end

endmodule

// ==== verilog/pkt_gen_top.sv ====
`timescale 1ns/10ps

module pkt_gen_top
    import pkt_gen_pkg::*;
#(
    parameter int DEFAULT_PKT_NUM  = 4,
    parameter int DEFAULT_PKT_SIZE = 522,
    parameter int INIT_WAIT        = 16
)
(
    input  logic                   clk,
    input  logic                   sys_reset,

    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [AXIL_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [AXIL_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,

    input  logic                   rx_aligned,
    input  logic                   tx_ovfout,
    input  logic                   tx_unfout,

    input  logic                   tready,
    output logic                   tvalid,
    output logic [DATA_W-1:0]      tdata,
    output logic [KEEP_W-1:0]      tkeep,
    output logic                   tlast
);

    logic                  start;
    logic [PKT_NUM_W-1:0]  pkt_num;
    logic [PKT_SIZE_W-1:0] pkt_size;
    logic                  load;
    logic                  stream_en;
    logic                  frames_done;
    logic                  busy;
    logic                  done;
    logic                  fail;
    logic                  aligned;

    pkt_gen_regs #(
        .DEFAULT_PKT_NUM  (DEFAULT_PKT_NUM),
        .DEFAULT_PKT_SIZE (DEFAULT_PKT_SIZE)
    ) regs_i (
        .clk       (clk),
        .sys_reset (sys_reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .start     (start),
        .pkt_num   (pkt_num),
        .pkt_size  (pkt_size),
        .busy      (busy),
        .done      (done),
        .fail      (fail),
        .aligned   (aligned)
    );

    pkt_gen_seq #(
        .INIT_WAIT (INIT_WAIT)
    ) seq_i (
        .clk         (clk),
        .sys_reset   (sys_reset),
        .start       (start),
        .rx_aligned  (rx_aligned),
        .tx_ovfout   (tx_ovfout),
        .tx_unfout   (tx_unfout),
        .frames_done (frames_done),
        .load        (load),
        .stream_en   (stream_en),
        .busy        (busy),
        .done        (done),
        .fail        (fail),
        .aligned     (aligned)
    );

    pkt_gen_frame frame_i (
        .clk         (clk),
        .sys_reset   (sys_reset),
        .load        (load),
        .stream_en   (stream_en),
        .pkt_num     (pkt_num),
        .pkt_size    (pkt_size),
        .tready      (tready),
        .tvalid      (tvalid),
        .tdata       (tdata),
        .tkeep       (tkeep),
        .tlast       (tlast),
        .frames_done (frames_done)
    );

endmodule

// ==== test/pkt_gen_props.sv ====
`timescale 1ns/10ps

module pkt_gen_props
    import pkt_gen_pkg::*;
(
    input logic              clk,
    input logic              sys_reset,
    input logic              tvalid,
    input logic              tready,
    input logic [DATA_W-1:0] tdata,
    input logic [KEEP_W-1:0] tkeep,
    input logic              tlast,
    input logic              bvalid,
    input logic              bready,
    input logic              rvalid,
    input logic              rready
);

    int failures = 0;

    // Offered beat holds until accepted
    stream_hold: assert property (@(posedge clk) disable iff (sys_reset)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast))
        else
        begin
            $error("stream beat changed or dropped before it was accepted");
            failures++;
        end

    // Partial keep only on a last beat
    keep_full: assert property (@(posedge clk) disable iff (sys_reset)
        tvalid && !tlast |-> tkeep == {KEEP_W{1'b1}})
        else
        begin
            $error("partial tkeep on a beat that is not the last");
            failures++;
        end

    write_resp_hold: assert property (@(posedge clk) disable iff (sys_reset)
        bvalid && !bready |=> bvalid)
        else
        begin
            $error("bvalid dropped before bready");
            failures++;
        end

    read_data_hold: assert property (@(posedge clk) disable iff (sys_reset)
        rvalid && !rready |=> rvalid)
        else
        begin
            $error("rvalid dropped before rready");
            failures++;
        end

endmodule

bind pkt_gen_top pkt_gen_props props_i (
    .clk       (clk),
    .sys_reset (sys_reset),
    .tvalid    (tvalid),
    .tready    (tready),
    .tdata     (tdata),
    .tkeep     (tkeep),
    .tlast     (tlast),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready)
);

// ==== test/pkt_gen_tb.sv ====
`timescale 1ns/10ps

module pkt_gen_tb
    import pkt_gen_pkg::*;
();

    logic                   clk;
    logic                   sys_reset;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic                   rvalid;
    logic                   rready;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rx_aligned;
    logic                   tx_ovfout;
    logic                   tx_unfout;
    logic                   tready;
    logic                   tvalid;
    logic [DATA_W-1:0]      tdata;
    logic [KEEP_W-1:0]      tkeep;
    logic                   tlast;

    logic [31:0]       lcg_state = 32'h2cd3;
    logic              random_ready;
    logic [DATA_W-1:0] beat_data[$];
    logic [KEEP_W-1:0] beat_keep[$];
    logic              beat_last[$];
    int                errors;
    int                test_errors;
    int                tests_run;
    int                tests_failed;

    pkt_gen_top #(
        .INIT_WAIT (4)
    ) dut_i (
        .clk        (clk),
        .sys_reset  (sys_reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rx_aligned (rx_aligned),
        .tx_ovfout  (tx_ovfout),
        .tx_unfout  (tx_unfout),
        .tready     (tready),
        .tvalid     (tvalid),
        .tdata      (tdata),
        .tkeep      (tkeep),
        .tlast      (tlast)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    initial
    begin : ready_driver
        logic [31:0] r;
        forever
        begin
            @(posedge clk);
            r = next_random();
            tready <= random_ready ? r[16] : 1'b1;
        end
    end

    task automatic monitor_stream();
        forever
        begin
            @(posedge clk);
            if (!sys_reset && tvalid && tready)
            begin
                beat_data.push_back(tdata);
                beat_keep.push_back(tkeep);
                beat_last.push_back(tlast);
            end
        end
    endtask

    initial
        monitor_stream();

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic check_value(input string test, input string what,
                               input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected)
        else
        begin
            $display("error %s %s: expected %0h, actual %0h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string test, input string msg);
        $display("%s: %s", test, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errors == 0)
            $display("test %s: ok", test);
        else
        begin
            $display("test %s: %0d errors", test, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    function automatic logic [AXIL_DATA_W-1:0] status_word(input logic busy, input logic done,
                                                           input logic fail, input logic aligned);
        logic [AXIL_DATA_W-1:0] w;
        w               = '0;
        w[STAT_BUSY]    = busy;
        w[STAT_DONE]    = done;
        w[STAT_FAIL]    = fail;
        w[STAT_ALIGNED] = aligned;
        return w;
    endfunction

    ////////////////////////////////////////
    // Bus drivers
    ////////////////////////////////////////
    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data);
        int         cnt;
        logic       got;
        logic       data_ready;
        logic [1:0] resp;
        data_ready = 1'b0;
        resp       = 2'b00;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        got = 1'b0;
        for (cnt = 0; cnt < 20 && !got; cnt++)
        begin
            @(posedge clk);
            got        = awready;
            data_ready = wready;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!got)
            report_failure("axil_write", "no awready before timeout");
        else
        begin
            check_value("axil_write", "wready with awready", 1, data_ready);
            got = 1'b0;
            for (cnt = 0; cnt < 20 && !got; cnt++)
            begin
                @(posedge clk);
                got  = bvalid;
                resp = bresp;
            end
            if (!got)
                report_failure("axil_write", "no write response before timeout");
            else
            begin
                check_value("axil_write", "bresp", 2'b00, resp);
                // Response waits a cycle before it is taken
                bready <= 1'b1;
                @(posedge clk);
                bready <= 1'b0;
            end
        end
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data);
        int         cnt;
        logic       got;
        logic [1:0] resp;
        data = '0;
        resp = 2'b00;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        got = 1'b0;
        for (cnt = 0; cnt < 20 && !got; cnt++)
        begin
            @(posedge clk);
            got = arready;
        end
        arvalid <= 1'b0;
        if (!got)
            report_failure("axil_read", "no arready before timeout");
        else
        begin
            got = 1'b0;
            for (cnt = 0; cnt < 20 && !got; cnt++)
            begin
                @(posedge clk);
                got  = rvalid;
                data = rdata;
                resp = rresp;
            end
            if (!got)
                report_failure("axil_read", "no read data before timeout");
            else
            begin
                check_value("axil_read", "rresp", 2'b00, resp);
                rready <= 1'b1;
                @(posedge clk);
                rready <= 1'b0;
            end
        end
    endtask

    // Polls STATUS until done
    task automatic wait_done(input string test, output logic [AXIL_DATA_W-1:0] status);
        int cnt;
        status = '0;
        for (cnt = 0; cnt < 400 && !status[STAT_DONE]; cnt++)
            axil_read(REG_STATUS, status);
        if (!status[STAT_DONE])
            report_failure(test, "run did not report done before timeout");
    endtask

    task automatic wait_tvalid(input string test);
        int   cnt;
        logic got;
        got = 1'b0;
        for (cnt = 0; cnt < 100 && !got; cnt++)
        begin
            @(posedge clk);
            got = tvalid;
        end
        if (!got)
            report_failure(test, "no tvalid before timeout");
    endtask

    task automatic start_run(input int num, input int size);
        beat_data.delete();
        beat_keep.delete();
        beat_last.delete();
        axil_write(REG_PKT_NUM, num);
        axil_write(REG_PKT_SIZE, size);
        axil_write(REG_CTRL, 32'd1);
    endtask

    // Reference model of one pattern byte per packet over full lanes
    task automatic check_stream(input string test, input int num, input int size);
        int                span;
        int                beats;
        int                idx;
        logic [7:0]        pat;
        logic [KEEP_W-1:0] keep;
        logic              last;
        span  = int'(PATTERN_LAST) - int'(PATTERN_FIRST) + 1;
        beats = (size + BEAT_BYTES - 1) / BEAT_BYTES;
        check_value(test, "beat count", num * beats, beat_data.size());
        idx = 0;
        for (int k = 0; k < num; k++)
        begin
            pat = 8'(int'(PATTERN_FIRST) + k % span);
            for (int b = 0; b < beats; b++)
            begin
                last = (b == beats - 1);
                keep = {KEEP_W{1'b1}};
                if (last && (size % BEAT_BYTES) != 0)
                    keep = (KEEP_W'(1) << (size % BEAT_BYTES)) - 1;
                if (idx < beat_data.size())
                begin
                    check_value(test, $sformatf("beat %0d tdata", idx),
                                {BEAT_BYTES{pat}}, beat_data[idx]);
                    check_value(test, $sformatf("beat %0d tkeep", idx), keep, beat_keep[idx]);
                    check_value(test, $sformatf("beat %0d tlast", idx), last, beat_last[idx]);
                end
                idx++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_registers();
        logic [AXIL_DATA_W-1:0] v;
        axil_read(REG_PKT_NUM, v);
        check_value("registers", "pkt_num default", 4, v);
        axil_read(REG_PKT_SIZE, v);
        check_value("registers", "pkt_size default", 522, v);
        axil_write(REG_PKT_NUM, 32'd7);
        axil_write(REG_PKT_SIZE, 32'd300);
        axil_read(REG_PKT_NUM, v);
        check_value("registers", "pkt_num", 7, v);
        axil_read(REG_PKT_SIZE, v);
        check_value("registers", "pkt_size", 300, v);
        axil_read(REG_CTRL, v);
        check_value("registers", "ctrl readback", 0, v);
        axil_read(REG_STATUS, v);
        check_value("registers", "status", status_word(0, 0, 0, 1), v);
        finish_test("registers");
    endtask

    task automatic test_basic_run();
        logic [AXIL_DATA_W-1:0] st;
        start_run(3, 130);
        wait_done("basic run", st);
        check_value("basic run", "status", status_word(0, 1, 0, 1), st);
        check_stream("basic run", 3, 130);
        finish_test("basic run");
    endtask

    task automatic test_back_pressure();
        logic [AXIL_DATA_W-1:0] st;
        random_ready <= 1'b1;
        start_run(5, 200);
        wait_done("back-pressure", st);
        random_ready <= 1'b0;
        check_value("back-pressure", "status", status_word(0, 1, 0, 1), st);
        check_stream("back-pressure", 5, 200);
        finish_test("back-pressure");
    endtask

    task automatic test_pattern_wrap();
        logic [AXIL_DATA_W-1:0] st;
        start_run(252, 64);
        wait_done("pattern wrap", st);
        check_value("pattern wrap", "status", status_word(0, 1, 0, 1), st);
        check_stream("pattern wrap", 252, 64);
        if (beat_data.size() > 250)
        begin
            check_value("pattern wrap", "packet 249 byte", 8'd255, beat_data[249][7:0]);
            check_value("pattern wrap", "packet 250 byte", 8'd6, beat_data[250][7:0]);
        end
        finish_test("pattern wrap");
    endtask

    task automatic test_mac_fault();
        logic [AXIL_DATA_W-1:0] st;
        start_run(4, 522);
        wait_tvalid("mac fault");
        tx_ovfout <= 1'b1;
        wait_done("mac fault", st);
        tx_ovfout <= 1'b0;
        check_value("mac fault", "status", status_word(0, 1, 1, 1), st);
        assert (beat_data.size() < 4 * 9)
        else
            report_failure("mac fault", "every beat was sent although the MAC reported overflow");
        // Clean run after the fault
        start_run(4, 522);
        wait_done("mac fault", st);
        check_value("mac fault", "status after restart", status_word(0, 1, 0, 1), st);
        check_stream("mac fault", 4, 522);
        finish_test("mac fault");
    endtask

    task automatic test_link_loss();
        logic [AXIL_DATA_W-1:0] st;
        logic                   seen;
        start_run(4, 522);
        wait_tvalid("link loss");
        rx_aligned <= 1'b0;
        wait_done("link loss", st);
        check_value("link loss", "status", status_word(0, 1, 1, 0), st);
        axil_write(REG_CTRL, 32'd1);
        seen = 1'b0;
        for (int i = 0; i < 50; i++)
        begin
            @(posedge clk);
            seen |= tvalid;
        end
        assert (!seen)
        else
            report_failure("link loss", "tvalid rose while the link was down");
        rx_aligned <= 1'b1;
        finish_test("link loss");
    endtask

    initial
    begin
        sys_reset    = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        rx_aligned   = 1'b1;
        tx_ovfout    = 1'b0;
        tx_unfout    = 1'b0;
        tready       = 1'b1;
        random_ready = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        sys_reset <= 1'b0;

        test_registers();
        test_basic_run();
        test_back_pressure();
        test_pattern_wrap();
        test_mac_fault();
        test_link_loss();

        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut_i.props_i.failures);
        if (errors == 0 && dut_i.props_i.failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/pkt_gen_pkg.sv
verilog/pkt_gen_regs.sv
verilog/pkt_gen_seq.sv
verilog/pkt_gen_frame.sv
verilog/pkt_gen_top.sv
test/pkt_gen_props.sv
test/pkt_gen_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_gen

sources:
  - verilog/pkt_gen_pkg.sv
  - verilog/pkt_gen_regs.sv
  - verilog/pkt_gen_seq.sv
  - verilog/pkt_gen_frame.sv
  - verilog/pkt_gen_top.sv
  - target: test
    files:
      - test/pkt_gen_props.sv
      - test/pkt_gen_tb.sv
